//--- hdl/serial_link_pkg.sv
`default_nettype none

package serial_link_pkg;

  ////////////////////////////////////////
  // Link constants
  ////////////////////////////////////////

  localparam int NumLanes      = 8;
  localparam int DataWidth     = 32;
  localparam int NumCredits    = 4;
  localparam int CreditWidth   = $clog2(NumCredits + 1);
  localparam int FrameWidth    = CreditWidth + 1 + DataWidth;
  // Flits per frame, last one zero-padded
  localparam int PayloadSplits = (FrameWidth + NumLanes - 1) / NumLanes;

  typedef logic [NumLanes-1:0]    flit_t;
  typedef logic [DataWidth-1:0]   data_t;
  typedef logic [CreditWidth-1:0] credit_t;
  typedef logic [2:0]             flit_cnt_t;

  // Credit-only frames carry a zero data field
  typedef enum logic {
    TagData   = 1'b0,
    TagCredit = 1'b1
  } tag_e;

  typedef enum logic {
    TxIdle,
    TxShift
  } tx_state_e;

  ////////////////////////////////////////
  // Frame and event records
  ////////////////////////////////////////

  // Data sits in the low bits, so flit 0 carries data[7:0]
  typedef struct packed {
    credit_t credit;
    tag_e    tag;
    data_t   data;
  } frame_t;

  typedef struct packed {
    logic    data_sent;
    logic    credit_sent;
    credit_t credit;
  } tx_event_t;

  typedef struct packed {
    logic    credit_valid;
    credit_t credit;
    logic    popped;
  } rx_event_t;

endpackage

`default_nettype wire

//--- hdl/serial_link_tx.sv
`default_nettype none

module serial_link_tx import serial_link_pkg::*; (
  input  logic      clk_i,
  input  logic      reset_i,
  // Local word stream
  input  data_t     data_i,
  input  logic      data_valid_i,
  output logic      data_ready_o,
  // From the credit manager
  input  logic      send_ok_i,
  input  credit_t   return_credit_i,
  input  logic      return_pending_i,
  // Wire side
  output flit_t     lane_o,
  output logic      lane_valid_o,
  output tx_event_t tx_event_o
);

  tx_state_e state_q, state_d;
  flit_cnt_t flit_cnt_q;
  logic [PayloadSplits*NumLanes-1:0] shift_q;

  logic   accept;
  logic   credit_only;
  logic   launch;
  frame_t frame;

  ////////////////////////////////////////
  // Frame launch
  ////////////////////////////////////////

  // A word is only taken while idle with at least one credit in hand
  assign data_ready_o = (state_q == TxIdle) && send_ok_i;
  assign accept       = data_valid_i && data_ready_o;

  // No word to send, but the peer is owed credits
  assign credit_only = (state_q == TxIdle) && !accept && return_pending_i;
  assign launch      = accept || credit_only;

  always_comb begin
    frame.data   = accept ? data_i : '0;
    frame.tag    = accept ? TagData : TagCredit;
    frame.credit = return_credit_i;
  end

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      TxIdle: begin
        if (launch) begin
          state_d = TxShift;
        end
      end
      TxShift: begin
        if (flit_cnt_q == flit_cnt_t'(PayloadSplits - 1)) begin
          state_d = TxIdle;
        end
      end
      default: state_d = TxIdle;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q    <= TxIdle;
      flit_cnt_q <= '0;
    end else begin
      state_q <= state_d;
      if (launch) begin
        flit_cnt_q <= '0;
      end else if (state_q == TxShift) begin
        flit_cnt_q <= flit_cnt_q + 1'b1;
      end
    end
  end

  ////////////////////////////////////////
  // Flit shifter
  ////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (launch) begin
      shift_q <= (PayloadSplits * NumLanes)'(frame);
    end else if (state_q == TxShift) begin
      shift_q <= shift_q >> NumLanes;
    end
  end

  // Lowest flit always sits at the bottom of the shifter
  assign lane_o       = shift_q[NumLanes-1:0];
  assign lane_valid_o = (state_q == TxShift);

  // Every launched frame carries the owed count, even when it is zero
  assign tx_event_o.data_sent   = accept;
  assign tx_event_o.credit_sent = launch;
  assign tx_event_o.credit      = return_credit_i;

endmodule

`default_nettype wire

//--- hdl/serial_link_rx.sv
`default_nettype none

module serial_link_rx import serial_link_pkg::*; (
  input  logic      clk_i,
  input  logic      reset_i,
  // Wire side
  input  flit_t     lane_i,
  input  logic      lane_valid_i,
  // Local word stream
  output data_t     data_o,
  output logic      data_valid_o,
  input  logic      data_ready_i,
  // To the credit manager
  output rx_event_t rx_event_o
);

  flit_cnt_t flit_cnt_q;
  logic      done_q;
  logic [PayloadSplits*NumLanes-1:0] asm_q;

  frame_t frame;
  logic   last_flit;
  logic   push;
  logic   pop;

  data_t                         fifo_mem [NumCredits];
  logic [$clog2(NumCredits)-1:0] wr_ptr_q;
  logic [$clog2(NumCredits)-1:0] rd_ptr_q;
  credit_t                       fill_q;

  ////////////////////////////////////////
  // Frame assembly
  ////////////////////////////////////////

  assign last_flit = (flit_cnt_q == flit_cnt_t'(PayloadSplits - 1));

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      flit_cnt_q <= '0;
      done_q     <= 1'b0;
    end else begin
      done_q <= lane_valid_i && last_flit;
      if (lane_valid_i) begin
        flit_cnt_q <= last_flit ? '0 : flit_cnt_q + 1'b1;
      end
    end
  end

  // New flits enter at the top, so flit 0 ends up in the low byte
  always_ff @(posedge clk_i) begin
    if (lane_valid_i) begin
      asm_q <= {lane_i, asm_q[PayloadSplits*NumLanes-1:NumLanes]};
    end
  end

  assign frame = frame_t'(asm_q[FrameWidth-1:0]);

  // Credit-only frames return credits but queue nothing
  assign push = done_q && (frame.tag == TagData);

  ////////////////////////////////////////
  // Receive FIFO
  ////////////////////////////////////////

  assign data_valid_o = (fill_q != '0);
  assign data_o       = fifo_mem[rd_ptr_q];
  assign pop          = data_valid_o && data_ready_i;

  always_ff @(posedge clk_i) begin
    if (push) begin
      fifo_mem[wr_ptr_q] <= frame.data;
    end
  end

  // Sender holds a credit per slot, so a push never finds the FIFO full
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      fill_q   <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == NumCredits - 1) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == NumCredits - 1) ? '0 : rd_ptr_q + 1'b1;
      end
      fill_q <= fill_q + credit_t'(push) - credit_t'(pop);
    end
  end

  assign rx_event_o.credit_valid = done_q;
  assign rx_event_o.credit       = frame.credit;
  assign rx_event_o.popped       = pop;

endmodule

`default_nettype wire

//--- hdl/serial_link_credit.sv
`default_nettype none

module serial_link_credit import serial_link_pkg::*; (
  input  logic      clk_i,
  input  logic      reset_i,
  input  tx_event_t tx_event_i,
  input  rx_event_t rx_event_i,
  output logic      send_ok_o,
  output credit_t   return_credit_o,
  output logic      return_pending_o
);

  // Slots free at the peer's receive FIFO
  credit_t avail_q;
  // Slots freed locally and not yet reported to the peer
  credit_t owed_q;

  credit_t avail_add;
  credit_t avail_sub;
  credit_t owed_add;
  credit_t owed_sub;

  ////////////////////////////////////////
  // Count updates
  ////////////////////////////////////////

  always_comb begin
    avail_add = rx_event_i.credit_valid ? rx_event_i.credit : '0;
    avail_sub = credit_t'(tx_event_i.data_sent);
    owed_add  = credit_t'(rx_event_i.popped);
    owed_sub  = tx_event_i.credit_sent ? tx_event_i.credit : '0;
  end

  // Add and subtract may land in the same cycle
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      avail_q <= credit_t'(NumCredits);
      owed_q  <= '0;
    end else begin
      avail_q <= avail_q + avail_add - avail_sub;
      owed_q  <= owed_q + owed_add - owed_sub;
    end
  end

  assign send_ok_o        = (avail_q != '0);
  assign return_credit_o  = owed_q;
  assign return_pending_o = (owed_q != '0);

endmodule

`default_nettype wire

//--- hdl/serial_link.sv
`default_nettype none

module serial_link import serial_link_pkg::*; (
  input  logic  clk_i,
  input  logic  reset_i,
  // Local input stream
  input  data_t data_i,
  input  logic  data_valid_i,
  output logic  data_ready_o,
  // Local output stream
  output data_t data_o,
  output logic  data_valid_o,
  input  logic  data_ready_i,
  // Lanes
  output flit_t lane_o,
  output logic  lane_valid_o,
  input  flit_t lane_i,
  input  logic  lane_valid_i
);

  tx_event_t tx_event;
  rx_event_t rx_event;
  logic      send_ok;
  credit_t   return_credit;
  logic      return_pending;

  ////////////////////////////////////////
  // Framer and deframer
  ////////////////////////////////////////

  serial_link_tx i_serial_link_tx (
    .clk_i            ( clk_i          ),
    .reset_i          ( reset_i        ),
    .data_i           ( data_i         ),
    .data_valid_i     ( data_valid_i   ),
    .data_ready_o     ( data_ready_o   ),
    .send_ok_i        ( send_ok        ),
    .return_credit_i  ( return_credit  ),
    .return_pending_i ( return_pending ),
    .lane_o           ( lane_o         ),
    .lane_valid_o     ( lane_valid_o   ),
    .tx_event_o       ( tx_event       )
  );

  serial_link_rx i_serial_link_rx (
    .clk_i        ( clk_i        ),
    .reset_i      ( reset_i      ),
    .lane_i       ( lane_i       ),
    .lane_valid_i ( lane_valid_i ),
    .data_o       ( data_o       ),
    .data_valid_o ( data_valid_o ),
    .data_ready_i ( data_ready_i ),
    .rx_event_o   ( rx_event     )
  );

  // Flow control between both directions
  serial_link_credit i_serial_link_credit (
    .clk_i            ( clk_i          ),
    .reset_i          ( reset_i        ),
    .tx_event_i       ( tx_event       ),
    .rx_event_i       ( rx_event       ),
    .send_ok_o        ( send_ok        ),
    .return_credit_o  ( return_credit  ),
    .return_pending_o ( return_pending )
  );

endmodule

`default_nettype wire

//--- bench/serial_link_assert.sv
`default_nettype none

module serial_link_assert import serial_link_pkg::*; (
  input wire logic    clk_i,
  input wire logic    reset_i,
  input wire credit_t avail_i,
  input wire credit_t owed_i,
  input wire logic    data_sent_i
);

  timeunit 1ns;
  timeprecision 100ps;

  ////////////////////////////////////////
  // Credit bounds
  ////////////////////////////////////////

  avail_bound: assert property (@(posedge clk_i) disable iff (reset_i)
    avail_i <= credit_t'(NumCredits))
    else $error("available credits above the receive FIFO depth");

  owed_bound: assert property (@(posedge clk_i) disable iff (reset_i)
    owed_i <= credit_t'(NumCredits))
    else $error("owed credits above the receive FIFO depth");

  // A data frame only leaves with a credit in hand
  send_needs_credit: assert property (@(posedge clk_i) disable iff (reset_i)
    data_sent_i |-> (avail_i != '0))
    else $error("data frame sent with no available credit");

endmodule

bind serial_link_credit serial_link_assert serial_link_assert_inst (
  .clk_i       ( clk_i                ),
  .reset_i     ( reset_i              ),
  .avail_i     ( avail_q              ),
  .owed_i      ( owed_q               ),
  .data_sent_i ( tx_event_i.data_sent )
);

`default_nettype wire

//--- bench/serial_link_tb.sv
`default_nettype none

module serial_link_tb import serial_link_pkg::*;;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int WaitLimit = 300;
  localparam int NumWords  = 60;

  logic  clk_i;
  logic  reset_i;
  data_t data_i;
  logic  data_valid_i;
  logic  data_ready_o;
  data_t data_o;
  logic  data_valid_o;
  logic  data_ready_i;
  flit_t lane;
  logic  lane_valid;

  data_t model_q[$];
  int    accept_cnt;
  int    burst_len;
  logic  rand_ready;

  // Lanes looped straight back into the receiver
  serial_link serial_link_inst (
    .clk_i        ( clk_i        ),
    .reset_i      ( reset_i      ),
    .data_i       ( data_i       ),
    .data_valid_i ( data_valid_i ),
    .data_ready_o ( data_ready_o ),
    .data_o       ( data_o       ),
    .data_valid_o ( data_valid_o ),
    .data_ready_i ( data_ready_i ),
    .lane_o       ( lane         ),
    .lane_valid_o ( lane_valid   ),
    .lane_i       ( lane         ),
    .lane_valid_i ( lane_valid   )
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  ////////////////////////////////////////
  // Error reporting and compares
  ////////////////////////////////////////

  task automatic stop_run();
    $display("Result: FAILED");
    $fatal(1, "Simulation stopped at first error");
  endtask

  task automatic report_problem(input string what);
    $display("Error: %s", what);
    stop_run();
  endtask

  task automatic check_word(input string name, input data_t got, input data_t exp);
    if (got !== exp) begin
      $display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
      stop_run();
    end
  endtask

  task automatic check_len(input string name, input flit_cnt_t got, input flit_cnt_t exp);
    if (got !== exp) begin
      $display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
      stop_run();
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
      stop_run();
    end
  endtask

  ////////////////////////////////////////
  // Monitor and reference model
  ////////////////////////////////////////

  always @(posedge clk_i) begin
    if (!reset_i) begin
      if (data_valid_i && data_ready_o) begin
        model_q.push_back(data_i);
        accept_cnt++;
        if (model_q.size() > NumCredits) begin
          report_problem("more words outstanding than receive credits");
        end
      end
      if (data_valid_o && data_ready_i) begin
        if (model_q.size() == 0) begin
          report_problem("data_o delivered a word that was never sent");
        end else begin
          check_word("data_o", data_o, model_q.pop_front());
        end
      end
      // Each burst on the lanes is one whole frame
      if (lane_valid) begin
        burst_len++;
        if (burst_len > PayloadSplits) begin
          report_problem("lane_valid_o burst longer than a frame");
        end
      end else if (burst_len != 0) begin
        check_len("lane burst length", flit_cnt_t'(burst_len), flit_cnt_t'(PayloadSplits));
        burst_len = 0;
      end
    end
  end

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  task automatic step();
    @(negedge clk_i);
    if (rand_ready) begin
      data_ready_i = ($urandom_range(3, 0) != 0);
    end
  endtask

  task automatic send_word(input data_t word);
    int start;
    int waited;
    start = accept_cnt;
    waited = 0;
    data_i = word;
    data_valid_i = 1'b1;
    while (accept_cnt == start) begin
      step();
      waited++;
      if (waited > WaitLimit) begin
        report_problem("input word was not accepted before the timeout");
      end
    end
    data_valid_i = 1'b0;
  endtask

  task automatic send_burst(input int count);
    repeat (count) begin
      repeat ($urandom_range(3, 0)) step();
      send_word($urandom());
    end
  endtask

  task automatic wait_drained();
    int waited;
    waited = 0;
    while (model_q.size() != 0) begin
      step();
      waited++;
      if (waited > WaitLimit) begin
        report_problem("receive side did not drain before the timeout");
      end
    end
  endtask

  initial begin
    int waited;
    void'($urandom(21));
    reset_i = 1'b1;
    data_i = '0;
    data_valid_i = 1'b0;
    data_ready_i = 1'b0;
    rand_ready = 1'b0;
    accept_cnt = 0;
    burst_len = 0;
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;
    check_flag("lane_valid_o", lane_valid, 1'b0);
    check_flag("data_valid_o", data_valid_o, 1'b0);
    check_flag("data_ready_o", data_ready_o, 1'b1);

    // Random traffic with random output stalls
    rand_ready = 1'b1;
    send_burst(NumWords);
    rand_ready = 1'b0;
    data_ready_i = 1'b1;
    wait_drained();

    // Output held off until the credits run out
    data_ready_i = 1'b0;
    while (model_q.size() < NumCredits) begin
      send_word($urandom());
    end
    repeat (4 * PayloadSplits) begin
      step();
      check_flag("data_ready_o", data_ready_o, 1'b0);
    end

    // Release, then credit-only frames must reopen the input
    data_ready_i = 1'b1;
    wait_drained();
    waited = 0;
    while (!data_ready_o) begin
      step();
      waited++;
      if (waited > WaitLimit) begin
        report_problem("data_ready_o stayed low after the stall was released");
      end
    end

    rand_ready = 1'b1;
    send_burst(NumWords / 2);
    rand_ready = 1'b0;
    data_ready_i = 1'b1;
    wait_drained();
    repeat (4 * PayloadSplits) step();

    // Once the owed credits are home the lanes fall quiet
    if (data_ready_o && !lane_valid) begin
      $display("Result: PASSED");
      $finish;
    end else begin
      $display("Error: link did not settle with the input ready and the lanes quiet");
      $display("Result: FAILED");
      $fatal(1, "Simulation stopped on a busy link");
    end
  end

endmodule

`default_nettype wire

//--- serial_link.f
hdl/serial_link_pkg.sv
hdl/serial_link_tx.sv
hdl/serial_link_rx.sv
hdl/serial_link_credit.sv
hdl/serial_link.sv
bench/serial_link_assert.sv
bench/serial_link_tb.sv
